//--- all.f
+incdir+verilog
verilog/rv32i_pkg.sv
verilog/control_unit.sv
verilog/imm_gen.sv
verilog/alu.sv
verilog/branch_cmp.sv
verilog/load_align.sv
verilog/regfile.sv
verilog/rv32i_core.sv
sim/tb_clock.sv
sim/rv32i_core_tb.sv

//--- sim/rv32i_core_tb.sv
`include "rv32i_cfg.svh"

module rv32i_core_tb
    import rv32i_pkg::*;
();
    timeunit 1ns;
    timeprecision 1ps;

    localparam int imem_words = 512;
    localparam int dmem_words = 1024;
    localparam int rand_count = 200;
    localparam int dump_at = 1 + rand_count;
    localparam int trap_at = dump_at + 32;
    localparam int prog_len = trap_at + 2;
    localparam int timeout_cycles = prog_len + 50;
    localparam int hold_cycles = 8;
    localparam int dump_offset = 128;
    localparam logic [11:0] data_base = 12'h400;
    localparam word_t trap_pc = `RESET_PC + 4 * trap_at;
    localparam word_t nop = 32'h0000_0013;

    logic  clk;
    logic  rst;
    word_t imem_rdata;
    word_t dmem_rdata;
    word_t imem_addr;
    word_t dmem_addr;
    word_t dmem_wdata;
    mask_t dmem_rmask;
    mask_t dmem_wmask;
    logic  dmem_read;
    logic  dmem_write;
    logic  trap;

    word_t  imem [imem_words];
    word_t  dmem [dmem_words];
    word_t  mmem [dmem_words];
    word_t  mregs [32];
    word_t  mpc;
    word_t  boot_instr;
    logic   exp_load;
    logic   exp_store;
    word_t  exp_addr;
    mask_t  exp_mask;
    word_t  exp_wdata;
    integer seed;
    int     checks = 0;
    int     errors = 0;
    int     cycles = 0;

    tb_clock clock_gen (.clk(clk), .rst(rst));

    rv32i_core UUT (
        .clk(clk), .rst(rst), .imem_rdata(imem_rdata), .dmem_rdata(dmem_rdata),
        .imem_addr(imem_addr), .dmem_addr(dmem_addr), .dmem_wdata(dmem_wdata),
        .dmem_rmask(dmem_rmask), .dmem_wmask(dmem_wmask), .dmem_read(dmem_read),
        .dmem_write(dmem_write), .trap(trap)
    );

    function automatic logic [8:0] imem_index(input word_t a);
        word_t ofs;
        ofs = a - `RESET_PC;
        return ofs[10:2];
    endfunction

    assign imem_rdata = imem[imem_index(imem_addr)];
    assign dmem_rdata = dmem[dmem_addr[11:2]];

    always @(posedge clk)
    begin : mem_write
        word_t merged;
        if (dmem_write)
        begin
            merged = dmem[dmem_addr[11:2]];
            for (int l = 0; l < 4; l++)
                if (dmem_wmask[l])
                    merged[8*l +: 8] = dmem_wdata[8*l +: 8];
            dmem[dmem_addr[11:2]] <= merged;
        end
    end

    always @(posedge clk)
    begin
        cycles++;
        if (cycles > timeout_cycles)
        begin
            $display("timeout: core did not reach the illegal instruction in %0d cycles",
                     timeout_cycles);
            finish_run(1'b1);
        end
    end

    function automatic int rand_below(input int n);
        return int'($unsigned($random(seed)) % n);
    endfunction

    function automatic word_t fill_word(input word_t a);
        return (a * 32'h9E37_79B1) ^ 32'h5A5A_C3C3;
    endfunction

    function automatic word_t lane_bits(input mask_t m);
        word_t bits;
        for (int l = 0; l < 4; l++)
            bits[8*l +: 8] = {8{m[l]}};
        return bits;
    endfunction

    function automatic word_t enc_i(input logic [11:0] imm, input reg_idx_t rs1,
                                    input logic [2:0] f3, input reg_idx_t rd,
                                    input opcode_t op);
        return {imm, rs1, f3, rd, op};
    endfunction

    function automatic word_t enc_s(input logic [11:0] imm, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3);
        return {imm[11:5], rs2, rs1, f3, imm[4:0], op_store};
    endfunction

    function automatic word_t enc_b(input logic [12:0] imm, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3);
        return {imm[12], imm[10:5], rs2, rs1, f3, imm[4:1], imm[11], op_br};
    endfunction

    function automatic word_t enc_u(input logic [19:0] imm, input reg_idx_t rd,
                                    input opcode_t op);
        return {imm, rd, op};
    endfunction

    function automatic word_t enc_j(input logic [20:0] imm, input reg_idx_t rd);
        return {imm[20], imm[10:1], imm[11], imm[19:12], rd, op_jal};
    endfunction

    function automatic word_t enc_r(input logic [6:0] f7, input reg_idx_t rs2,
                                    input reg_idx_t rs1, input logic [2:0] f3,
                                    input reg_idx_t rd);
        return {f7, rs2, rs1, f3, rd, op_reg};
    endfunction

    // x1 holds the data base and is never a destination.
    task automatic build_program;
        int         i;
        int         kind;
        int         r;
        logic [2:0] f3;
        logic [6:0] f7;
        logic [11:0] imm;
        reg_idx_t   rd;
        for (i = 0; i < imem_words; i++)
            imem[i] = nop;
        imem[0] = enc_i(data_base, 5'd0, 3'd0, 5'd1, op_imm);
        i = 1;
        while (i < dump_at)
        begin
            kind = rand_below(10);
            rd = reg_idx_t'(2 + rand_below(30));
            // forward targets stay inside the random section.
            if (kind >= 7 && i + 4 > dump_at)
                kind = 3;
            case (kind)
                0: imem[i] = enc_u(20'(rand_below(1 << 20)), rd, op_lui);
                1: imem[i] = enc_u(20'(rand_below(1 << 20)), rd, op_auipc);
                2:
                begin
                    f3 = 3'(rand_below(8));
                    imm = 12'(rand_below(4096));
                    if (f3 == 3'd1 || f3 == 3'd5)
                        imm[11:5] = (f3 == 3'd5 && rand_below(2) == 1) ? 7'h20 : 7'h00;
                    imem[i] = enc_i(imm, reg_idx_t'(rand_below(32)), f3, rd, op_imm);
                end
                3, 4:
                begin
                    f3 = 3'(rand_below(8));
                    f7 = ((f3 == 3'd0 || f3 == 3'd5) && rand_below(2) == 1) ? 7'h20 : 7'h00;
                    imem[i] = enc_r(f7, reg_idx_t'(rand_below(32)),
                                    reg_idx_t'(rand_below(32)), f3, rd);
                end
                5:
                begin
                    r = rand_below(5);
                    f3 = (r < 3) ? 3'(r) : 3'(r + 1);
                    imem[i] = enc_i(12'(rand_below(64)), 5'd1, f3, rd, op_load);
                end
                6:
                    imem[i] = enc_s(12'(rand_below(64)), reg_idx_t'(rand_below(32)), 5'd1,
                                    3'(rand_below(3)));
                7:
                begin
                    r = rand_below(6);
                    f3 = (r < 2) ? 3'(r) : 3'(r + 2);
                    imem[i] = enc_b(13'(4 * (1 + rand_below(3))), reg_idx_t'(rand_below(32)),
                                    reg_idx_t'(rand_below(32)), f3);
                end
                8: imem[i] = enc_j(21'(4 * (1 + rand_below(3))), rd);
                // absolute target from x0 with an odd offset now and then.
                default:
                    imem[i] = enc_i(12'(`RESET_PC + 4 * (i + 1 + rand_below(3)) + rand_below(2)),
                                    5'd0, 3'd0, rd, op_jalr);
            endcase
            i++;
        end
        for (i = 0; i < 32; i++)
            imem[dump_at + i] = enc_s(12'(dump_offset + 4 * i), reg_idx_t'(i), 5'd1, sw);
        imem[trap_at] = 32'h0000_0000;
        imem[trap_at + 1] = enc_s(12'd0, 5'd5, 5'd1, sw);
    endtask

    function automatic word_t arith(input logic [2:0] f3, input logic alt,
                                    input word_t a, input word_t b);
        case (f3)
            3'd0: return alt ? a - b : a + b;
            3'd1: return a << b[4:0];
            3'd2: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            3'd3: return (a < b) ? 32'd1 : 32'd0;
            3'd4: return a ^ b;
            3'd5: return alt ? word_t'($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'd6: return a | b;
            default: return a & b;
        endcase
    endfunction

    // reference model, one instruction per call.
    task automatic model_step;
        word_t      ins;
        word_t      rs1v;
        word_t      rs2v;
        word_t      imm_i;
        word_t      imm_s;
        word_t      imm_b;
        word_t      imm_u;
        word_t      imm_j;
        word_t      addr;
        word_t      res;
        word_t      w;
        word_t      bval;
        word_t      hval;
        word_t      nxt;
        logic [2:0] f3;
        logic       wr;
        logic       taken;
        ins = imem[imem_index(mpc)];
        f3 = ins[14:12];
        rs1v = mregs[ins[19:15]];
        rs2v = mregs[ins[24:20]];
        imm_i = {{20{ins[31]}}, ins[31:20]};
        imm_s = {{20{ins[31]}}, ins[31:25], ins[11:7]};
        imm_b = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
        imm_u = {ins[31:12], 12'h000};
        imm_j = {{12{ins[31]}}, ins[19:12], ins[20], ins[30:21], 1'b0};
        nxt = mpc + 4;
        res = '0;
        wr = 1'b0;
        exp_load = 1'b0;
        exp_store = 1'b0;
        case (opcode_t'(ins[6:0]))
            op_lui:
            begin
                res = imm_u;
                wr = 1'b1;
            end
            op_auipc:
            begin
                res = mpc + imm_u;
                wr = 1'b1;
            end
            op_jal:
            begin
                res = mpc + 4;
                wr = 1'b1;
                nxt = mpc + imm_j;
            end
            op_jalr:
            begin
                res = mpc + 4;
                wr = 1'b1;
                nxt = (rs1v + imm_i) & 32'hFFFF_FFFE;
            end
            op_br:
            begin
                case (f3)
                    3'd0: taken = (rs1v == rs2v);
                    3'd1: taken = (rs1v != rs2v);
                    3'd4: taken = ($signed(rs1v) < $signed(rs2v));
                    3'd5: taken = ($signed(rs1v) >= $signed(rs2v));
                    3'd6: taken = (rs1v < rs2v);
                    default: taken = (rs1v >= rs2v);
                endcase
                if (taken)
                    nxt = mpc + imm_b;
            end
            op_load:
            begin
                addr = rs1v + imm_i;
                w = mmem[addr[11:2]];
                bval = w >> (8 * addr[1:0]);
                hval = addr[1] ? w >> 16 : w;
                case (f3)
                    3'd0: res = {{24{bval[7]}}, bval[7:0]};
                    3'd1: res = {{16{hval[15]}}, hval[15:0]};
                    3'd4: res = {24'd0, bval[7:0]};
                    3'd5: res = {16'd0, hval[15:0]};
                    default: res = w;
                endcase
                if (f3 == 3'd0 || f3 == 3'd4)
                    exp_mask = 4'b0001 << addr[1:0];
                else if (f3 == 3'd1 || f3 == 3'd5)
                    exp_mask = addr[1] ? 4'b1100 : 4'b0011;
                else
                    exp_mask = 4'b1111;
                exp_load = 1'b1;
                exp_addr = {addr[31:2], 2'b00};
                wr = 1'b1;
            end
            op_store:
            begin
                addr = rs1v + imm_s;
                if (f3 == 3'd0)
                begin
                    exp_mask = 4'b0001 << addr[1:0];
                    exp_wdata = rs2v << (8 * addr[1:0]);
                end
                else if (f3 == 3'd1)
                begin
                    exp_mask = addr[1] ? 4'b1100 : 4'b0011;
                    exp_wdata = addr[1] ? rs2v << 16 : rs2v;
                end
                else
                begin
                    exp_mask = 4'b1111;
                    exp_wdata = rs2v;
                end
                exp_store = 1'b1;
                exp_addr = {addr[31:2], 2'b00};
                mmem[addr[11:2]] = (mmem[addr[11:2]] & ~lane_bits(exp_mask))
                                   | (exp_wdata & lane_bits(exp_mask));
            end
            op_imm:
            begin
                res = arith(f3, (f3 == 3'd5) ? ins[30] : 1'b0, rs1v, imm_i);
                wr = 1'b1;
            end
            op_reg:
            begin
                res = arith(f3, ins[30], rs1v, rs2v);
                wr = 1'b1;
            end
            default: ;
        endcase
        if (wr && ins[11:7] != 5'd0)
            mregs[ins[11:7]] = res;
        mpc = nxt;
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("** Error %s: expected %h, actual %h", name, expected, actual);
        end
    endtask

    task automatic check_mask(input string name, input mask_t expected, input mask_t actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("** Error %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic check_bit(input string name, input logic expected, input logic actual);
        checks++;
        if (actual !== expected)
        begin
            errors++;
            $display("** Error %s: expected %b, actual %b", name, expected, actual);
        end
    endtask

    task automatic check_instruction;
        word_t lanes;
        check_word("pc", mpc, imem_addr);
        check_bit("trap", 1'b0, trap);
        model_step();
        check_bit("dmem_read", exp_load, dmem_read);
        check_bit("dmem_write", exp_store, dmem_write);
        if (exp_load)
        begin
            check_word("load address", exp_addr, dmem_addr);
            check_mask("load rmask", exp_mask, dmem_rmask);
        end
        if (exp_store)
        begin
            lanes = lane_bits(exp_mask);
            check_word("store address", exp_addr, dmem_addr);
            check_mask("store wmask", exp_mask, dmem_wmask);
            check_word("store data", exp_wdata & lanes, dmem_wdata & lanes);
        end
    endtask

    task automatic finish_run(input logic timed_out);
        $display("checks %0d, errors %0d", checks, errors);
        if (errors == 0 && !timed_out)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    endtask

    initial
    begin
        seed = 48;
        build_program();
        for (int a = 0; a < dmem_words; a++)
        begin
            dmem[a] = fill_word(word_t'(a * 4));
            mmem[a] = dmem[a];
        end
        for (int r = 0; r < 32; r++)
            mregs[r] = '0;
        mpc = `RESET_PC;

        // a load and then a store sit at the reset pc while rst is high.
        boot_instr = imem[0];
        imem[0] = enc_i(12'd0, 5'd0, lw, 5'd0, op_load);

        @(posedge clk);
        @(negedge clk);
        check_word("reset pc", `RESET_PC, imem_addr);
        check_bit("reset dmem_read", 1'b0, dmem_read);
        check_bit("reset dmem_write", 1'b0, dmem_write);
        imem[0] = enc_s(12'd0, 5'd0, 5'd0, sw);

        @(negedge clk);
        check_word("reset pc", `RESET_PC, imem_addr);
        check_bit("reset dmem_read", 1'b0, dmem_read);
        check_bit("reset dmem_write", 1'b0, dmem_write);
        imem[0] = boot_instr;

        // rst falls on the first of these edges while instruction 0 is the addi.
        while (mpc != trap_pc)
        begin
            @(negedge clk);
            check_instruction();
        end

        repeat (hold_cycles)
        begin
            @(negedge clk);
            check_word("trap pc", trap_pc, imem_addr);
            check_bit("trap raised", 1'b1, trap);
            check_bit("write after trap", 1'b0, dmem_write);
        end

        for (int n = 0; n < 32; n++)
            check_word($sformatf("dump x%0d", n), mregs[n],
                       dmem[(32'h400 + dump_offset + 4 * n) >> 2]);
        for (int a = 32'h400; a < 32'h500; a += 4)
            check_word($sformatf("data word %h", a), mmem[a >> 2], dmem[a >> 2]);

        finish_run(1'b0);
    end

endmodule

//--- sim/tb_clock.sv
module tb_clock (
    output logic clk,
    output logic rst
);
    timeunit 1ns;
    timeprecision 1ps;

    // 8 ns period.
    initial
    begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    // three rising edges in reset, released on a falling edge.
    initial
    begin
        rst = 1'b1;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
    end

endmodule

//--- verilog/rv32i_core.sv
`include "rv32i_cfg.svh"

module rv32i_core
    import rv32i_pkg::*;
(
    input  logic  clk,
    input  logic  rst,
    input  word_t imem_rdata,
    input  word_t dmem_rdata,
    output word_t imem_addr,
    output word_t dmem_addr,
    output word_t dmem_wdata,
    output mask_t dmem_rmask,
    output mask_t dmem_wmask,
    output logic  dmem_read,
    output logic  dmem_write,
    output logic  trap
);

    word_t     pc;
    word_t     pc_inc;
    word_t     pc_next;
    word_t     instr;
    opcode_t   opcode;
    word_t     rs1_data;
    word_t     rs2_data;
    word_t     i_imm;
    word_t     s_imm;
    word_t     b_imm;
    word_t     u_imm;
    word_t     j_imm;
    word_t     alu_a;
    word_t     alu_b;
    word_t     alu_result;
    word_t     cmp_b;
    word_t     load_data;
    word_t     wb_data;
    logic      br_en;
    alu_op_t   alu_op;
    alu_src1_t alu_src1;
    alu_src2_t alu_src2;
    rd_src_t   rd_src;
    pc_src_t   pc_src;
    logic      reg_write;
    logic      mem_read;
    logic      mem_write;
    logic [4:0] store_shift;

    assign instr     = imem_rdata;
    assign opcode    = opcode_t'(instr[6:0]);
    assign imem_addr = pc;
    assign pc_inc    = pc + 32'd4;

    // a trapped instruction holds the pc, so trap stays up until reset.
    always_ff @(posedge clk)
    begin
        if (rst)
            pc <= `RESET_PC;
        else if (!trap)
            pc <= pc_next;
    end

    control_unit ctrl (
        .opcode(opcode), .funct3(instr[14:12]), .funct7(instr[31:25]),
        .addr_low(alu_result[1:0]), .br_en(br_en), .alu_op(alu_op),
        .alu_src1(alu_src1), .alu_src2(alu_src2), .rd_src(rd_src), .pc_src(pc_src),
        .reg_write(reg_write), .mem_read(mem_read), .mem_write(mem_write),
        .rmask(dmem_rmask), .wmask(dmem_wmask), .trap(trap)
    );

    imm_gen imm (
        .instr(instr), .i_imm(i_imm), .s_imm(s_imm), .b_imm(b_imm),
        .u_imm(u_imm), .j_imm(j_imm)
    );

    regfile rf (
        .clk(clk), .rst(rst), .we(reg_write & ~rst), .rs1(instr[19:15]),
        .rs2(instr[24:20]), .rd(instr[11:7]), .wdata(wb_data),
        .rs1_data(rs1_data), .rs2_data(rs2_data)
    );

    assign alu_a = (alu_src1 == src1_pc) ? pc : rs1_data;

    always_comb
    begin
        case (alu_src2)
            src2_i_imm: alu_b = i_imm;
            src2_s_imm: alu_b = s_imm;
            src2_b_imm: alu_b = b_imm;
            src2_u_imm: alu_b = u_imm;
            src2_j_imm: alu_b = j_imm;
            default:    alu_b = rs2_data;
        endcase
    end

    alu alu_i (.op(alu_op), .a(alu_a), .b(alu_b), .result(alu_result));

    // slti and sltiu compare against the immediate.
    assign cmp_b = (opcode == op_imm) ? i_imm : rs2_data;

    branch_cmp cmp (
        .funct3(instr[14:12]), .is_branch(opcode == op_br), .a(rs1_data),
        .b(cmp_b), .br_en(br_en)
    );

    load_align ld (
        .funct3(instr[14:12]), .addr_low(alu_result[1:0]), .rdata(dmem_rdata),
        .load_data(load_data)
    );

    always_comb
    begin
        case (rd_src)
            rd_cmp_out:   wb_data = {31'd0, br_en};
            rd_u_imm:     wb_data = u_imm;
            rd_pc_plus4:  wb_data = pc_inc;
            rd_load_data: wb_data = load_data;
            default:      wb_data = alu_result;
        endcase
    end

    always_comb
    begin
        case (pc_src)
            alu_target:      pc_next = alu_result;
            alu_target_even: pc_next = {alu_result[31:1], 1'b0};
            default:         pc_next = pc_inc;
        endcase
    end

    // move store data into the lanes picked by wmask.
    always_comb
    begin
        case (store_funct3_t'(instr[14:12]))
            sb:      store_shift = {alu_result[1:0], 3'b000};
            sh:      store_shift = {alu_result[1], 4'b0000};
            default: store_shift = 5'd0;
        endcase
    end

    assign dmem_wdata = rs2_data << store_shift;
    assign dmem_addr  = {alu_result[31:2], 2'b00};
    assign dmem_read  = mem_read & ~rst;
    assign dmem_write = mem_write & ~rst;

endmodule

//--- verilog/regfile.sv
`include "rv32i_cfg.svh"

module regfile
    import rv32i_pkg::*;
(
    input  logic     clk,
    input  logic     rst,
    input  logic     we,
    input  reg_idx_t rs1,
    input  reg_idx_t rs2,
    input  reg_idx_t rd,
    input  word_t    wdata,
    output word_t    rs1_data,
    output word_t    rs2_data
);

    word_t regs [`REG_COUNT];

    // x0 is cleared here and never written, so it reads as zero.
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            for (int i = 0; i < `REG_COUNT; i++)
                regs[i] <= '0;
        end
        else if (we && rd != '0)
            regs[rd] <= wdata;
    end

    assign rs1_data = regs[rs1];
    assign rs2_data = regs[rs2];

endmodule

//--- verilog/load_align.sv
module load_align
    import rv32i_pkg::*;
(
    input  logic [2:0] funct3,
    input  logic [1:0] addr_low,
    input  word_t      rdata,
    output word_t      load_data
);

    word_t byte_shifted;
    word_t half_shifted;

    // bring the addressed lane down to bit 0.
    assign byte_shifted = rdata >> {addr_low, 3'b000};
    assign half_shifted = rdata >> {addr_low[1], 4'b0000};

    always_comb
    begin
        case (load_funct3_t'(funct3))
            lb:
                load_data = {{24{byte_shifted[7]}}, byte_shifted[7:0]};
            lbu:
                load_data = {24'h000000, byte_shifted[7:0]};
            lh:
                load_data = {{16{half_shifted[15]}}, half_shifted[15:0]};
            lhu:
                load_data = {16'h0000, half_shifted[15:0]};
            default:
                load_data = rdata;
        endcase
    end

endmodule

//--- verilog/branch_cmp.sv
module branch_cmp
    import rv32i_pkg::*;
(
    input  logic [2:0] funct3,
    input  logic       is_branch,
    input  word_t      a,
    input  word_t      b,
    output logic       br_en
);

    logic equal;
    logic less_s;
    logic less_u;

    assign equal  = (a == b);
    assign less_s = ($signed(a) < $signed(b));
    assign less_u = (a < b);

    always_comb
    begin
        if (is_branch)
        begin
            case (branch_funct3_t'(funct3))
                beq:     br_en = equal;
                bne:     br_en = ~equal;
                blt:     br_en = less_s;
                bge:     br_en = ~less_s;
                bltu:    br_en = less_u;
                bgeu:    br_en = ~less_u;
                default: br_en = 1'b0;
            endcase
        end
        else
            br_en = (arith_funct3_t'(funct3) == sltu) ? less_u : less_s;
    end

endmodule

//--- verilog/alu.sv
module alu
    import rv32i_pkg::*;
(
    input  alu_op_t op,
    input  word_t   a,
    input  word_t   b,
    output word_t   result
);

    logic [4:0] shamt;

    // rv32 shifts use only the low five bits.
    assign shamt = b[4:0];

    always_comb
    begin
        case (op)
            alu_add: result = a + b;
            alu_sub: result = a - b;
            alu_sll: result = a << shamt;
            alu_xor: result = a ^ b;
            alu_srl: result = a >> shamt;
            alu_sra: result = word_t'($signed(a) >>> shamt);
            alu_or:  result = a | b;
            alu_and: result = a & b;
            default: result = a + b;
        endcase
    end

endmodule

//--- verilog/imm_gen.sv
module imm_gen
    import rv32i_pkg::*;
(
    input  word_t instr,
    output word_t i_imm,
    output word_t s_imm,
    output word_t b_imm,
    output word_t u_imm,
    output word_t j_imm
);

    logic sign;

    assign sign = instr[31];

    assign i_imm = {{20{sign}}, instr[31:20]};
    assign s_imm = {{20{sign}}, instr[31:25], instr[11:7]};

    // branch and jump offsets are in halfwords, bit 0 is always zero.
    assign b_imm = {{19{sign}}, sign, instr[7], instr[30:25], instr[11:8], 1'b0};
    assign j_imm = {{11{sign}}, sign, instr[19:12], instr[20], instr[30:21], 1'b0};

    assign u_imm = {instr[31:12], 12'h000};

endmodule

//--- verilog/control_unit.sv
module control_unit
    import rv32i_pkg::*;
(
    input  opcode_t    opcode,
    input  logic [2:0] funct3,
    input  logic [6:0] funct7,
    input  logic [1:0] addr_low,
    input  logic       br_en,
    output alu_op_t    alu_op,
    output alu_src1_t  alu_src1,
    output alu_src2_t  alu_src2,
    output rd_src_t    rd_src,
    output pc_src_t    pc_src,
    output logic       reg_write,
    output logic       mem_read,
    output logic       mem_write,
    output mask_t      rmask,
    output mask_t      wmask,
    output logic       trap
);

    branch_funct3_t branch_f3;
    load_funct3_t   load_f3;
    store_funct3_t  store_f3;
    arith_funct3_t  arith_f3;
    mask_t          byte_mask;
    mask_t          half_mask;
    logic           write_reg;
    logic           write_mem;

    // slt and sltu go through branch_cmp, the alu result is unused there.
    function automatic alu_op_t arith_alu_op(input arith_funct3_t f3, input logic alt,
                                             input logic reg_form);
        case (f3)
            add:     return (alt && reg_form) ? alu_sub : alu_add;
            sll:     return alu_sll;
            axor:    return alu_xor;
            sr:      return alt ? alu_sra : alu_srl;
            aor:     return alu_or;
            aand:    return alu_and;
            default: return alu_sub;
        endcase
    endfunction

    assign branch_f3 = branch_funct3_t'(funct3);
    assign load_f3   = load_funct3_t'(funct3);
    assign store_f3  = store_funct3_t'(funct3);
    assign arith_f3  = arith_funct3_t'(funct3);

    // halfwords look at address bit 1 only.
    assign byte_mask = mask_t'(4'b0001 << addr_low);
    assign half_mask = addr_low[1] ? 4'b1100 : 4'b0011;

    always_comb
    begin
        trap  = 1'b0;
        rmask = '0;
        wmask = '0;
        case (opcode)
            op_lui, op_auipc, op_jal, op_imm, op_reg: ;
            op_jalr:
                trap = (funct3 != 3'b000);
            op_br:
            begin
                case (branch_f3)
                    beq, bne, blt, bge, bltu, bgeu: ;
                    default: trap = 1'b1;
                endcase
            end
            op_load:
            begin
                case (load_f3)
                    lw:       rmask = 4'b1111;
                    lh, lhu:  rmask = half_mask;
                    lb, lbu:  rmask = byte_mask;
                    default:  trap = 1'b1;
                endcase
            end
            op_store:
            begin
                case (store_f3)
                    sw:      wmask = 4'b1111;
                    sh:      wmask = half_mask;
                    sb:      wmask = byte_mask;
                    default: trap = 1'b1;
                endcase
            end
            default: trap = 1'b1;
        endcase
    end

    always_comb
    begin
        alu_op    = alu_add;
        alu_src1  = src1_rs1;
        alu_src2  = src2_rs2;
        rd_src    = rd_alu_out;
        pc_src    = pc_plus4;
        write_reg = 1'b0;
        mem_read  = 1'b0;
        write_mem = 1'b0;
        case (opcode)
            op_lui:
            begin
                write_reg = 1'b1;
                rd_src    = rd_u_imm;
            end
            op_auipc:
            begin
                write_reg = 1'b1;
                alu_src1  = src1_pc;
                alu_src2  = src2_u_imm;
            end
            op_jal:
            begin
                write_reg = 1'b1;
                alu_src1  = src1_pc;
                alu_src2  = src2_j_imm;
                rd_src    = rd_pc_plus4;
                pc_src    = alu_target;
            end
            op_jalr:
            begin
                write_reg = 1'b1;
                alu_src2  = src2_i_imm;
                rd_src    = rd_pc_plus4;
                pc_src    = alu_target_even;
            end
            op_br:
            begin
                alu_src1 = src1_pc;
                alu_src2 = src2_b_imm;
                pc_src   = br_en ? alu_target : pc_plus4;
            end
            op_load:
            begin
                write_reg = 1'b1;
                mem_read  = 1'b1;
                alu_src2  = src2_i_imm;
                rd_src    = rd_load_data;
            end
            op_store:
            begin
                write_mem = 1'b1;
                alu_src2  = src2_s_imm;
            end
            op_imm, op_reg:
            begin
                write_reg = 1'b1;
                alu_op    = arith_alu_op(arith_f3, funct7[5], opcode == op_reg);
                if (opcode == op_imm)
                    alu_src2 = src2_i_imm;
                if (arith_f3 == slt || arith_f3 == sltu)
                    rd_src = rd_cmp_out;
            end
            default: ;
        endcase
    end

    // an illegal instruction must leave no architectural trace.
    assign reg_write = write_reg & ~trap;
    assign mem_write = write_mem & ~trap;

endmodule

//--- verilog/rv32i_pkg.sv
package rv32i_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0] reg_idx_t;
    typedef logic [3:0] mask_t;

    typedef enum logic [6:0] {
        op_lui   = 7'b0110111,
        op_auipc = 7'b0010111,
        op_jal   = 7'b1101111,
        op_jalr  = 7'b1100111,
        op_br    = 7'b1100011,
        op_load  = 7'b0000011,
        op_store = 7'b0100011,
        op_imm   = 7'b0010011,
        op_reg   = 7'b0110011
    } opcode_t;

    typedef enum logic [2:0] {
        beq  = 3'b000,
        bne  = 3'b001,
        blt  = 3'b100,
        bge  = 3'b101,
        bltu = 3'b110,
        bgeu = 3'b111
    } branch_funct3_t;

    typedef enum logic [2:0] {
        lb  = 3'b000,
        lh  = 3'b001,
        lw  = 3'b010,
        lbu = 3'b100,
        lhu = 3'b101
    } load_funct3_t;

    typedef enum logic [2:0] {
        sb = 3'b000,
        sh = 3'b001,
        sw = 3'b010
    } store_funct3_t;

    // sr covers both srl and sra, split by funct7 bit 5.
    typedef enum logic [2:0] {
        add  = 3'b000,
        sll  = 3'b001,
        slt  = 3'b010,
        sltu = 3'b011,
        axor = 3'b100,
        sr   = 3'b101,
        aor  = 3'b110,
        aand = 3'b111
    } arith_funct3_t;

    typedef enum logic [3:0] {
        alu_add = 4'd0,
        alu_sub = 4'd1,
        alu_sll = 4'd2,
        alu_xor = 4'd3,
        alu_srl = 4'd4,
        alu_sra = 4'd5,
        alu_or  = 4'd6,
        alu_and = 4'd7
    } alu_op_t;

    typedef enum logic {src1_rs1, src1_pc} alu_src1_t;

    typedef enum logic [2:0] {
        src2_rs2, src2_i_imm, src2_s_imm, src2_b_imm, src2_u_imm, src2_j_imm
    } alu_src2_t;

    typedef enum logic [2:0] {
        rd_alu_out, rd_cmp_out, rd_u_imm, rd_pc_plus4, rd_load_data
    } rd_src_t;

    typedef enum logic [1:0] {pc_plus4, alu_target, alu_target_even} pc_src_t;

endpackage

//--- verilog/rv32i_cfg.svh
`ifndef RV32I_CFG_SVH
`define RV32I_CFG_SVH

// pc loaded while rst is high.
`define RESET_PC 32'h0000_0000

// architectural integer registers.
`define REG_COUNT 32

`endif
